// ==== logic/dcache_geom_pkg.sv ====
`default_nettype none

package dcache_geom_pkg;

	typedef logic [31:0] word_t;

	localparam int num_sets = 8; // two-way, so 16 lines total
	localparam int idx_w    = 3;
	localparam int tag_w    = 26;

	typedef logic [idx_w-1:0] idx_t;
	typedef logic [tag_w-1:0] tag_t;

	// address as the cache splits it
	typedef struct packed {
		tag_t       tag;    // [31:6]
		idx_t       idx;    // [5:3]
		logic       blkoff; // word within the block
		logic [1:0] bytoff; // always 0 for word access
	} dcache_addr_f_t;

	// one 32-bit address seen two ways, raw word for the bus, fields for lookup
	typedef union packed {
		word_t          word;
		dcache_addr_f_t f;
	} dcache_addr_t;

	typedef struct packed {
		tag_t            tag;
		word_t [1:0]     block; // block[1] is the upper word
		logic            valid;
		logic            dirty;
	} cache_line_t;

endpackage

`default_nettype wire

// ==== logic/dcache_bus_pkg.sv ====
`default_nettype none

package dcache_bus_pkg;

	// processor to cache
	typedef struct packed {
		logic                         ren;
		logic                         wen;
		logic                         halt;  // held while idle until flushed
		dcache_geom_pkg::dcache_addr_t addr;
		dcache_geom_pkg::word_t       store;
	} dp_req_t;

	typedef struct packed {
		logic                   hit;
		logic                   flushed;
		dcache_geom_pkg::word_t load;
	} dp_rsp_t;

	// cache to memory, ren and wen are plain levels
	typedef struct packed {
		logic                   ren;
		logic                   wen;
		dcache_geom_pkg::word_t addr;
		dcache_geom_pkg::word_t store;
	} mem_req_t;

	typedef struct packed {
		logic                   dwait; // memory still busy, transfer done when low
		dcache_geom_pkg::word_t load;
	} mem_rsp_t;

	// write command into one way
	typedef struct packed {
		logic                   en;       // write one word of row idx
		logic                   clear;    // zero the whole way
		dcache_geom_pkg::idx_t  idx;
		logic                   word_sel;
		dcache_geom_pkg::tag_t  tag;
		dcache_geom_pkg::word_t data;
		logic                   valid;
		logic                   dirty;
	} way_wr_t;

endpackage

`default_nettype wire

// ==== logic/dcache_way.sv ====
`default_nettype none

module dcache_way (
	input  logic                         CLK,
	input  logic                         nRST,
	input  dcache_geom_pkg::idx_t        lookup_idx,
	input  dcache_geom_pkg::tag_t        lookup_tag,
	input  dcache_bus_pkg::way_wr_t      wr,
	output logic                         hit,
	output dcache_geom_pkg::cache_line_t line
);

	// one row per set, kept in flops so the lookup is combinational
	dcache_geom_pkg::cache_line_t [dcache_geom_pkg::num_sets-1:0] rows;

	assign line = rows[lookup_idx];
	assign hit  = line.valid && (line.tag == lookup_tag); // request qualify is done upstream

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			rows <= '0;
		end else if (wr.clear) begin
			rows <= '0; // end of flush, whole way invalid
		end else if (wr.en) begin
			rows[wr.idx].tag                <= wr.tag;
			rows[wr.idx].block[wr.word_sel] <= wr.data; // other word untouched
			rows[wr.idx].valid              <= wr.valid;
			rows[wr.idx].dirty              <= wr.dirty;
		end
	end

	// controller never asks for a word write while clearing
	a_wr_clear_excl: assert property (@(posedge CLK) disable iff (!nRST)
		!(wr.en && wr.clear));

endmodule

`default_nettype wire

// ==== logic/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl (
	input  logic                         CLK,
	input  logic                         nRST,
	input  dcache_bus_pkg::dp_req_t      req,
	output dcache_bus_pkg::dp_rsp_t      rsp,
	output dcache_bus_pkg::mem_req_t     mreq,
	input  dcache_bus_pkg::mem_rsp_t     mrsp,
	input  logic                         hit0,
	input  logic                         hit1,
	input  dcache_geom_pkg::cache_line_t line0,
	input  dcache_geom_pkg::cache_line_t line1,
	output dcache_geom_pkg::idx_t        lookup_idx,
	output dcache_geom_pkg::tag_t        lookup_tag,
	output dcache_bus_pkg::way_wr_t      wr0,
	output dcache_bus_pkg::way_wr_t      wr1
);

	typedef enum logic [3:0] {
		IDLE, WB1, WB2, FETCH1, FETCH2,
		FLUSH1, FLUSH2, FLUSH3, FLUSH4, DONE
	} state_t;

	state_t state, next_state;

	logic [dcache_geom_pkg::num_sets-1:0] lru; // per set, the way to evict next
	dcache_geom_pkg::idx_t flush_idx;
	logic flush_step;    // move on to the next set
	logic access;        // processor wants a word
	logic hit_any;
	logic victim;        // lru way of the requested set
	logic upper;         // states that move the high word
	logic flushing;
	logic fdirty;        // current flush word must go out
	logic wsel;          // way that takes wcmd
	dcache_geom_pkg::cache_line_t vline, fline;
	dcache_geom_pkg::dcache_addr_t bus_addr;
	dcache_bus_pkg::way_wr_t wcmd;

	assign access   = req.ren || req.wen;
	assign flushing = state inside {FLUSH1, FLUSH2, FLUSH3, FLUSH4};
	assign upper    = state inside {WB2, FETCH2, FLUSH2, FLUSH4};

	// ways look at the flush set while flushing, else at the request
	assign lookup_idx = flushing ? flush_idx : req.addr.f.idx;
	assign lookup_tag = req.addr.f.tag;

	assign hit_any = (state == IDLE) && access && (hit0 || hit1);
	assign victim  = lru[req.addr.f.idx];
	assign vline   = victim ? line1 : line0;
	assign fline   = (state == FLUSH3 || state == FLUSH4) ? line1 : line0; // way 0 goes first
	assign fdirty  = fline.valid && fline.dirty;

	always_comb begin
		rsp.hit     = hit_any;
		rsp.flushed = (state == DONE); // stays up, DONE has no exit
		rsp.load    = hit1 ? line1.block[req.addr.f.blkoff] : line0.block[req.addr.f.blkoff];
	end

	always_comb begin
		next_state = state;
		flush_step = 1'b0;
		mreq.ren   = 1'b0;
		mreq.wen   = 1'b0;
		mreq.store = '0;
		bus_addr   = '0;
		bus_addr.f.idx    = lookup_idx;
		bus_addr.f.blkoff = upper;
		wcmd          = '0;
		wcmd.idx      = lookup_idx;
		wcmd.tag      = req.addr.f.tag;
		wcmd.word_sel = upper;
		wsel          = victim; // fills go to the lru way

		case (state)
			IDLE: begin
				if (req.halt) begin
					next_state = FLUSH1;
				end else if (hit_any) begin
					wsel          = hit1;
					wcmd.en       = req.wen; // write hit lands at this edge
					wcmd.word_sel = req.addr.f.blkoff;
					wcmd.data     = req.store;
					wcmd.valid    = 1'b1;
					wcmd.dirty    = 1'b1;
				end else if (access) begin
					next_state = (vline.valid && vline.dirty) ? WB1 : FETCH1;
				end
			end
			WB1, WB2: begin
				// old block goes back under its own tag
				mreq.wen        = 1'b1;
				bus_addr.f.tag  = vline.tag;
				mreq.store      = vline.block[upper];
				if (!mrsp.dwait) begin
					next_state = (state == WB1) ? WB2 : FETCH1;
				end
			end
			FETCH1, FETCH2: begin
				mreq.ren       = 1'b1;
				bus_addr.f.tag = req.addr.f.tag;
				wcmd.en        = !mrsp.dwait; // store the word as it arrives
				wcmd.data      = mrsp.load;
				wcmd.valid     = (state == FETCH2); // block usable only once both words are in
				if (!mrsp.dwait) begin
					next_state = (state == FETCH1) ? FETCH2 : IDLE;
				end
			end
			FLUSH1, FLUSH2, FLUSH3, FLUSH4: begin
				mreq.wen       = fdirty; // clean words are skipped in one cycle
				bus_addr.f.tag = fline.tag;
				mreq.store     = fline.block[upper];
				if (!fdirty || !mrsp.dwait) begin
					if (state == FLUSH1) begin
						next_state = FLUSH2;
					end else if (state == FLUSH2) begin
						next_state = FLUSH3;
					end else if (state == FLUSH3) begin
						next_state = FLUSH4;
					end else if (flush_idx ==
							dcache_geom_pkg::idx_t'(dcache_geom_pkg::num_sets - 1)) begin
						next_state = DONE;
						wcmd.clear = 1'b1; // table wiped once on the way into DONE
					end else begin
						next_state = FLUSH1;
						flush_step = 1'b1;
					end
				end
			end
			default: ; // DONE, parked for good
		endcase

		mreq.addr = bus_addr.word;
	end

	always_comb begin
		wr0       = wcmd;
		wr1       = wcmd;
		wr0.en    = wcmd.en && !wsel;
		wr1.en    = wcmd.en && wsel;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state     <= IDLE;
			lru       <= '0;
			flush_idx <= '0;
		end else begin
			state <= next_state;
			if (hit_any) begin
				lru[req.addr.f.idx] <= !hit1; // point at the way not just used
			end
			if (flush_step) begin
				flush_idx <= flush_idx + 1'b1;
			end
		end
	end

	// a stalled transfer keeps the whole request until memory takes it
	a_bus_hold: assert property (@(posedge CLK) disable iff (!nRST)
		(mreq.ren || mreq.wen) && mrsp.dwait |=> $stable(mreq));

	// table already wiped whenever flushed is seen
	a_flushed_done: assert property (@(posedge CLK) disable iff (!nRST)
		rsp.flushed |-> !hit0 && !hit1);

	// a tag lives in at most one way of a set
	a_hit_excl: assert property (@(posedge CLK) disable iff (!nRST)
		!(hit0 && hit1));

endmodule

`default_nettype wire

// ==== logic/dcache_top.sv ====
`default_nettype none

module dcache_top (
	input  logic                     CLK,
	input  logic                     nRST,
	input  dcache_bus_pkg::dp_req_t  dp_req,
	output dcache_bus_pkg::dp_rsp_t  dp_rsp,
	output dcache_bus_pkg::mem_req_t mem_req,
	input  dcache_bus_pkg::mem_rsp_t mem_rsp
);

	dcache_geom_pkg::idx_t        lookup_idx;
	dcache_geom_pkg::tag_t        lookup_tag;
	dcache_bus_pkg::way_wr_t      wr0, wr1;
	logic                         hit0, hit1;
	dcache_geom_pkg::cache_line_t line0, line1;

	// both ways see the same lookup and compare tags side by side
	dcache_way way0 (
		.CLK        (CLK),
		.nRST       (nRST),
		.lookup_idx (lookup_idx),
		.lookup_tag (lookup_tag),
		.wr         (wr0),
		.hit        (hit0),
		.line       (line0)
	);

	dcache_way way1 (
		.CLK        (CLK),
		.nRST       (nRST),
		.lookup_idx (lookup_idx),
		.lookup_tag (lookup_tag),
		.wr         (wr1),
		.hit        (hit1),
		.line       (line1)
	);

	dcache_ctrl ctrl (
		.CLK        (CLK),
		.nRST       (nRST),
		.req        (dp_req),
		.rsp        (dp_rsp),
		.mreq       (mem_req),
		.mrsp       (mem_rsp),
		.hit0       (hit0),
		.hit1       (hit1),
		.line0      (line0),
		.line1      (line1),
		.lookup_idx (lookup_idx),
		.lookup_tag (lookup_tag),
		.wr0        (wr0),
		.wr1        (wr1)
	);

endmodule

`default_nettype wire

// ==== dv/mem_model.sv ====
`default_nettype none

module mem_model (
	input  logic                     CLK,
	input  logic                     nRST,
	input  dcache_bus_pkg::mem_req_t req,
	output dcache_bus_pkg::mem_rsp_t rsp
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int depth = 1024; // 4 KiB of words, test addresses stay below

	dcache_geom_pkg::word_t words [0:depth-1];
	int unsigned wr_count [0:depth-1]; // write log, one count per word
	logic [31:0] rnd;                  // xorshift state, low bits give the wait count
	logic [1:0]  waited;
	logic        active;
	logic [9:0]  widx;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	assign active    = req.ren || req.wen;
	assign widx      = req.addr[11:2];
	assign rsp.dwait = active && (waited != rnd[1:0]); // 0 to 3 wait cycles up front
	assign rsp.load  = words[widx];

	// preload, word address xor a fixed marker
	initial begin
		for (int i = 0; i < depth; i++) begin
			words[i]    = 32'(i) ^ 32'h5a5a0000;
			wr_count[i] = 0;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			rnd    <= 32'he1c6;
			waited <= '0;
		end else if (active && rsp.dwait) begin
			waited <= waited + 2'd1;
		end else if (active) begin
			waited <= '0;
			rnd    <= xorshift32(rnd); // new wait count for the next transfer
		end
	end

	always @(posedge CLK) begin
		if (nRST && req.wen && !rsp.dwait) begin
			words[widx]    <= req.store;
			wr_count[widx] <= wr_count[widx] + 1;
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_dcache.sv ====
`default_nettype none

module tb_dcache;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic        wr;
		logic [1:0]  kind; // 0 any, 1 must hit at once, 2 must miss first
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp;  // reference word before this row
	} row_t;

	localparam int          hit_limit   = 200;
	localparam int          flush_limit = 4000;
	localparam logic [31:0] evict_addr  = 32'h0000_0090; // tag 2 in set 2

	logic CLK = 1'b0;
	logic nRST;
	dcache_bus_pkg::dp_req_t  dp_req;
	dcache_bus_pkg::dp_rsp_t  dp_rsp;
	dcache_bus_pkg::mem_req_t mem_req;
	dcache_bus_pkg::mem_rsp_t mem_rsp;

	row_t        rows [$];
	logic [31:0] model_mem [0:1023]; // what memory plus cache should hold
	logic [31:0] rnd = 32'he1c6;
	int          mismatches = 0;
	int          faults = 0;
	int          bus_mismatches = 0;
	int          bus_faults = 0;
	logic        held_wait = 1'b0;
	logic [31:0] held_addr = '0;
	logic        ok; // cleared by a timeout

	dcache_top dut (
		.CLK     (CLK),
		.nRST    (nRST),
		.dp_req  (dp_req),
		.dp_rsp  (dp_rsp),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	mem_model mem (
		.CLK  (CLK),
		.nRST (nRST),
		.req  (mem_req),
		.rsp  (mem_rsp)
	);

	always #4 CLK = ~CLK;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic read_step(input logic [31:0] a, input logic [1:0] kind);
		rows.push_back({1'b0, kind, a, 32'h0, model_mem[a[11:2]]});
	endtask

	task automatic write_step(input logic [31:0] a, input logic [31:0] d, input logic [1:0] kind);
		rows.push_back({1'b1, kind, a, d, model_mem[a[11:2]]});
		model_mem[a[11:2]] = d;
	endtask

	// hold the request until hit, count the cycles spent waiting
	task automatic apply_row(input row_t r);
		int cycles;
		cycles       = 0;
		dp_req.ren   = !r.wr;
		dp_req.wen   = r.wr;
		dp_req.addr.word = r.addr;
		dp_req.store = r.data;
		@(negedge CLK);
		while (!dp_rsp.hit && cycles < hit_limit) begin
			cycles++;
			@(negedge CLK);
		end
		if (!dp_rsp.hit) begin
			faults++;
			ok = 1'b0;
			$display("timeout at %0t: no hit for address %h in %0d cycles", $time, r.addr, hit_limit);
		end else begin
			if (!r.wr) begin
				assert (dp_rsp.load == r.exp) else begin
					mismatches++;
					$display("MISMATCH @%0t: load from %h is %h, expected %h",
						$time, r.addr, dp_rsp.load, r.exp);
				end
			end
			assert (r.kind != 2'd1 || cycles == 0) else begin
				faults++;
				$display("address %h should hit at once but took %0d cycles", r.addr, cycles);
			end
			assert (r.kind != 2'd2 || cycles > 0) else begin
				faults++;
				$display("address %h should miss but hit at once", r.addr);
			end
		end
		@(posedge CLK); // write taken at this edge
		#1;
		dp_req.ren = 1'b0;
		dp_req.wen = 1'b0;
	endtask

	// memory bus rules, sampled mid-cycle
	always @(negedge CLK) begin
		if (nRST) begin
			assert (!(mem_req.ren && mem_req.wen)) else begin
				bus_faults++;
				$display("bus fault at %0t: ren and wen high together", $time);
			end
			if (held_wait) begin
				assert ((mem_req.ren || mem_req.wen) && mem_req.addr == held_addr) else begin
					bus_mismatches++;
					$display("MISMATCH @%0t: memory address %h, expected %h held through wait",
						$time, mem_req.addr, held_addr);
				end
			end
			held_wait = (mem_req.ren || mem_req.wen) && mem_rsp.dwait;
			held_addr = mem_req.addr;
		end
	end

	initial begin
		int cycles;
		nRST   = 1'b0;
		dp_req = '0;
		ok     = 1'b1;
		for (int i = 0; i < 1024; i++) begin
			model_mem[i] = 32'(i) ^ 32'h5a5a0000;
		end

		read_step(32'h100, 2'd2);                // cold block
		read_step(32'h104, 2'd1);                // its upper word
		write_step(32'h104, 32'hcafe_0104, 2'd1);
		read_step(32'h104, 2'd1);
		read_step(32'h100, 2'd1);                // neighbour untouched
		write_step(32'h050, 32'ha000_0050, 2'd2); // set 2, tag 1
		write_step(evict_addr, 32'hb000_0090, 2'd2); // set 2, tag 2
		read_step(32'h050, 2'd1);                // tag 1 touched last
		read_step(32'h0d0, 2'd2);                // tag 3 evicts dirty tag 2
		read_step(32'h050, 2'd1);
		read_step(evict_addr, 2'd2);             // comes back from memory
		for (int i = 0; i < 16; i++) begin
			logic [31:0] a;
			rnd = xorshift32(rnd);
			a   = {22'h0, rnd[9:2], 2'b00};
			if (rnd[16]) begin
				write_step(a, xorshift32(rnd), 2'd0);
			end else begin
				read_step(a, 2'd0);
			end
		end

		repeat (10) @(posedge CLK);
		#1;
		nRST = 1'b1;
		@(negedge CLK);
		assert (!dp_rsp.hit && !dp_rsp.flushed && !mem_req.ren && !mem_req.wen) else begin
			faults++;
			$display("outputs not idle after reset at %0t", $time);
		end
		@(posedge CLK);
		#1;

		for (int i = 0; i < rows.size() && ok; i++) begin
			apply_row(rows[i]);
		end

		if (ok) begin
			assert (mem.wr_count[evict_addr[11:2]] != 0) else begin
				faults++;
				$display("write log has no write-back for address %h", evict_addr);
			end
			dp_req.halt = 1'b1;
			cycles      = 0;
			@(negedge CLK);
			while (!dp_rsp.flushed && cycles < flush_limit) begin
				cycles++;
				@(negedge CLK);
			end
			if (!dp_rsp.flushed) begin
				faults++;
				$display("timeout: flushed did not rise within %0d cycles", flush_limit);
			end else begin
				for (int i = 0; i < 1024; i++) begin
					assert (mem.words[i] == model_mem[i]) else begin
						mismatches++;
						$display("MISMATCH @%0t: memory word at %h is %h, expected %h",
							$time, i * 4, mem.words[i], model_mem[i]);
					end
				end
			end
		end

		$display("summary: %0d mismatches, %0d other errors",
			mismatches + bus_mismatches, faults + bus_faults);
		if (mismatches + bus_mismatches + faults + bus_faults == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/dcache_geom_pkg.sv
logic/dcache_bus_pkg.sv
logic/dcache_way.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/mem_model.sv
dv/tb_dcache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the dcache testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_dcache -f flist.f --Mdir obj_dir -o sim_dcache

./obj_dir/sim_dcache > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
	echo "run.sh: simulation passed"
	exit 0
else
	echo "run.sh: simulation failed, see sim.log"
	exit 1
fi
